//--- sources.f
design/i2c_timing_pkg.sv
design/i2c_cond_pkg.sv
design/i2c_period_counter.sv
design/i2c_start_gen.sv
design/i2c_restart_gen.sv
design/i2c_stop_gen.sv
design/i2c_cond_gen.sv
test/i2c_cond_gen_assertions.sv
test/tb_i2c_cond_gen.sv

//--- Makefile
# Verilator build, run and lint of the I2C condition generator testbench

VERILATOR ?= verilator
TOP       ?= tb_i2c_cond_gen
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)

run: build
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- test/tb_i2c_cond_gen.sv
// testbench with clock, reset, SCL loopback, LFSR timing, directed tests, watchdog and summary
`default_nettype none
`timescale 1ns/1ps

module tb_i2c_cond_gen;

    localparam int CLK_PERIOD = 8;
    localparam int MAX_PERIOD = 15;
    localparam int STRETCH_CYCLES = 9;
    // three timed phases, each with its entry and exit cycles, plus the stretch
    localparam int SEQ_LIMIT = 3 * (MAX_PERIOD + 3) + STRETCH_CYCLES + 4;
    localparam int TIMED_PHASES = 18;
    localparam int WATCHDOG_CYCLES = TIMED_PHASES * (MAX_PERIOD + 3) + STRETCH_CYCLES + 100;

    localparam i2c_cond_pkg::line_drive_t SCL_LOW_ONLY = '{scl: 1'b0, sda: 1'b1};
    localparam i2c_cond_pkg::line_drive_t SDA_LOW_ONLY = '{scl: 1'b1, sda: 1'b0};
    localparam i2c_cond_pkg::line_drive_t BOTH_LOW = '{scl: 1'b0, sda: 1'b0};

    logic clk, rst_n, scl_int, stretch;
    logic start_en, restart_en, stop_en;
    logic start_sda, start_done, restart_done, stop_done;
    i2c_timing_pkg::i2c_timing_t timing;
    i2c_cond_pkg::line_drive_t restart_line, stop_line;
    logic [15:0] lfsr;
    int cyc = 0;
    int errors = 0;
    int checks = 0;

    // a slave stretching the clock pulls the sensed SCL low together with the DUT
    assign scl_int = restart_line.scl & stop_line.scl & stretch;

    i2c_cond_gen i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_period(output i2c_timing_pkg::count_t p);
        logic [3:0] b;
        int i;
        for (i = 0; i < 4; i++) begin
            b[i] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
        p = (b == 4'd0) ? 16'd1 : {12'd0, b};
    endtask

    task automatic randomize_timing();
        draw_period(timing.scl_low);
        draw_period(timing.setup);
        draw_period(timing.hold);
    endtask

    task automatic check(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("error at %0t ns: %s", $time, what);
        end
    endtask

    // START only drives SDA, so its SCL is always seen as released
    function automatic i2c_cond_pkg::line_drive_t line_of(input int gen);
        case (gen)
            0: return '{scl: 1'b1, sda: start_sda};
            1: return restart_line;
            default: return stop_line;
        endcase
    endfunction

    function automatic logic done_of(input int gen);
        case (gen)
            0: return start_done;
            1: return restart_done;
            default: return stop_done;
        endcase
    endfunction

    task automatic set_enable(input int gen, input logic value);
        @(negedge clk);
        case (gen)
            0: start_en = value;
            1: restart_en = value;
            default: stop_en = value;
        endcase
    endtask

    task automatic release_and_check(input int gen);
        set_enable(gen, 1'b0);
        @(negedge clk);
        check(!done_of(gen) && line_of(gen) == i2c_cond_pkg::RELEASED,
              $sformatf("generator %0d not idle after its enable dropped", gen));
    endtask

    task automatic test_reset_idle();
        @(negedge clk);
        check(!start_done && !restart_done && !stop_done, "a done is high after reset");
        check(start_sda && restart_line == i2c_cond_pkg::RELEASED &&
              stop_line == i2c_cond_pkg::RELEASED, "a line is driven low after reset");
    endtask

    task automatic test_start();
        int k, t_fall;
        t_fall = -1;
        randomize_timing();
        set_enable(0, 1'b1);
        for (k = 0; k < SEQ_LIMIT && !start_done; k++) begin
            @(negedge clk);
            check(restart_line.scl && stop_line.scl, "SCL pulled low during START");
            if (t_fall < 0 && !start_sda) t_fall = cyc;
            if (start_done) begin
                check(t_fall >= 0 && !start_sda && cyc - t_fall >= int'(timing.hold),
                      "start_done rose before the hold period or with SDA high");
            end
        end
        check(start_done, "START did not raise start_done in time");
        release_and_check(0);
    endtask

    // follows three line states in order, stretching SCL for n_stretch cycles in setup
    task automatic run_sequence(input int gen, input i2c_cond_pkg::line_drive_t p0,
                                input i2c_cond_pkg::line_drive_t p1,
                                input i2c_cond_pkg::line_drive_t p2, input int n_stretch);
        int phase, k, t0, t1;
        i2c_cond_pkg::line_drive_t seen;
        phase = -1;
        t0 = 0;
        t1 = 0;
        randomize_timing();
        set_enable(gen, 1'b1);
        for (k = 0; k < SEQ_LIMIT && !done_of(gen); k++) begin
            @(negedge clk);
            seen = line_of(gen);
            if (phase < 0 && seen == p0) begin
                phase = 0;
                t0 = cyc;
            end else if (phase == 0 && seen == p1) begin
                phase = 1;
                t1 = cyc;
                check(t1 - t0 >= int'(timing.scl_low), "SCL low phase shorter than scl_low");
            end else if (phase == 1 && seen == p2) begin
                phase = 2;
                check(cyc - t1 >= n_stretch + int'(timing.setup), "setup phase ended early");
            end else begin
                check(phase >= 0 && seen == ((phase == 0) ? p0 : (phase == 1) ? p1 : p2),
                      $sformatf("generator %0d shows line state %b out of order", gen, seen));
            end
            if (phase == 1) stretch = (cyc - t1 >= n_stretch);
            if (done_of(gen)) begin
                check(phase == 2 && seen == p2 && cyc - t1 >= n_stretch + int'(timing.setup),
                      $sformatf("generator %0d raised done too early", gen));
            end
        end
        stretch = 1'b1;
        check(done_of(gen), $sformatf("generator %0d did not raise done in time", gen));
        release_and_check(gen);
    endtask

    task automatic test_restart(input int n_stretch);
        run_sequence(1, SCL_LOW_ONLY, i2c_cond_pkg::RELEASED, SDA_LOW_ONLY, n_stretch);
    endtask

    task automatic test_stop();
        run_sequence(2, BOTH_LOW, SDA_LOW_ONLY, i2c_cond_pkg::RELEASED, 0);
    endtask

    task automatic test_abort(input int gen);
        randomize_timing();
        set_enable(gen, 1'b1);
        @(negedge clk);
        check(line_of(gen) != i2c_cond_pkg::RELEASED,
              $sformatf("generator %0d not mid-sequence before the abort", gen));
        release_and_check(gen);
    endtask

    initial begin
        lfsr = 16'd8188;
        rst_n = 1'b0;
        stretch = 1'b1;
        timing = '0;
        start_en = 1'b0;
        restart_en = 1'b0;
        stop_en = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset_idle();
        test_start();
        test_restart(0);
        test_stop();
        test_restart(STRETCH_CYCLES);
        test_abort(0);
        test_start();
        test_abort(1);
        test_restart(0);
        test_abort(2);
        test_stop();
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/i2c_cond_gen_assertions.sv
// concurrent checks on the done levels and line states of the I2C condition generator top
`default_nettype none
`timescale 1ns/1ps

module i2c_cond_gen_assertions (
    input wire                            clk,
    input wire                            rst_n,
    input wire                            start_en,
    input wire                            restart_en,
    input wire                            stop_en,
    input wire                            start_done,
    input wire                            restart_done,
    input wire                            stop_done,
    input wire i2c_cond_pkg::line_drive_t restart_line,
    input wire i2c_cond_pkg::line_drive_t stop_line
);

    // every done is registered from a next state that only leaves idle while the enable is high
    start_done_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
        start_done |-> $past(start_en))
        else $error("start_done high without start_en in the previous cycle");

    restart_done_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
        restart_done |-> $past(restart_en))
        else $error("restart_done high without restart_en in the previous cycle");

    stop_done_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
        stop_done |-> $past(stop_en))
        else $error("stop_done high without stop_en in the previous cycle");

    // a finished repeated START keeps SDA low under a high SCL
    restart_done_lines: assert property (@(posedge clk) disable iff (!rst_n)
        restart_done |-> (restart_line.scl && !restart_line.sda))
        else $error("restart_done high while lines are not SCL high and SDA low");

    stop_done_lines: assert property (@(posedge clk) disable iff (!rst_n)
        stop_done |-> (stop_line == i2c_cond_pkg::RELEASED))
        else $error("stop_done high while a STOP line is still driven low");

endmodule

bind i2c_cond_gen i2c_cond_gen_assertions i_assertions (.*);

`default_nettype wire

//--- design/i2c_cond_gen.sv
// top level joining the START, repeated START and STOP condition generators
`default_nettype none
`timescale 1ns/1ps

module i2c_cond_gen (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire i2c_timing_pkg::i2c_timing_t timing,
    input  wire                              scl_int,
    input  wire                              start_en,
    input  wire                              restart_en,
    input  wire                              stop_en,
    output logic                             start_sda,
    output i2c_cond_pkg::line_drive_t        restart_line,
    output i2c_cond_pkg::line_drive_t        stop_line,
    output logic                             start_done,
    output logic                             restart_done,
    output logic                             stop_done
);

    i2c_start_gen i_start_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .timing     (timing),
        .scl_int    (scl_int),
        .start_en   (start_en),
        .start_sda  (start_sda),
        .start_done (start_done)
    );

    i2c_restart_gen i_restart_gen (
        .clk          (clk),
        .rst_n        (rst_n),
        .timing       (timing),
        .scl_int      (scl_int),
        .restart_en   (restart_en),
        .restart_line (restart_line),
        .restart_done (restart_done)
    );

    i2c_stop_gen i_stop_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .timing    (timing),
        .scl_int   (scl_int),
        .stop_en   (stop_en),
        .stop_line (stop_line),
        .stop_done (stop_done)
    );

endmodule

`default_nettype wire

//--- design/i2c_stop_gen.sv
// STOP condition FSM with SCL low and setup period counters
`default_nettype none
`timescale 1ns/1ps

module i2c_stop_gen (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire i2c_timing_pkg::i2c_timing_t timing,
    input  wire                              scl_int,
    input  wire                              stop_en,
    output i2c_cond_pkg::line_drive_t        stop_line,
    output logic                             stop_done
);

    i2c_cond_pkg::stop_state_t state, nx_state;
    logic low_load, setup_load;
    logic low_complete, setup_complete;

    i2c_period_counter i_scl_low_cnt (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (low_load),
        .en       (state == i2c_cond_pkg::STOP_SCL_LOW),
        .period   (timing.scl_low),
        .complete (low_complete)
    );

    i2c_period_counter i_setup_cnt (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (setup_load),
        .en       ((state == i2c_cond_pkg::STOP_SETUP) && scl_int),
        .period   (timing.setup),
        .complete (setup_complete)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= i2c_cond_pkg::STOP_IDLE;
        end else begin
            state <= nx_state;
        end
    end

    always_comb begin
        nx_state = state;
        if (!stop_en) begin
            nx_state = i2c_cond_pkg::STOP_IDLE;
        end else begin
            case (state)
                i2c_cond_pkg::STOP_IDLE: nx_state = i2c_cond_pkg::STOP_SCL_LOW;
                i2c_cond_pkg::STOP_SCL_LOW: begin
                    if (low_complete && !low_load) begin
                        nx_state = i2c_cond_pkg::STOP_SETUP;
                    end
                end
                i2c_cond_pkg::STOP_SETUP: begin
                    if (setup_complete && !setup_load) begin
                        nx_state = i2c_cond_pkg::STOP_DONE;
                    end
                end
                default: nx_state = i2c_cond_pkg::STOP_DONE;
            endcase
        end
    end

    // SDA rises while SCL is high, which is the STOP itself
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            low_load   <= 1'b0;
            setup_load <= 1'b0;
            stop_line  <= i2c_cond_pkg::RELEASED;
            stop_done  <= 1'b0;
        end else begin
            low_load   <= (nx_state == i2c_cond_pkg::STOP_SCL_LOW) &&
                          (state != i2c_cond_pkg::STOP_SCL_LOW);
            setup_load <= (nx_state == i2c_cond_pkg::STOP_SETUP) &&
                          (state != i2c_cond_pkg::STOP_SETUP);
            stop_done  <= (nx_state == i2c_cond_pkg::STOP_DONE);
            case (nx_state)
                i2c_cond_pkg::STOP_SCL_LOW: stop_line <= '{scl: 1'b0, sda: 1'b0};
                i2c_cond_pkg::STOP_SETUP:   stop_line <= '{scl: 1'b1, sda: 1'b0};
                default:                    stop_line <= i2c_cond_pkg::RELEASED;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/i2c_restart_gen.sv
// repeated START FSM with SCL low, setup and hold period counters
`default_nettype none
`timescale 1ns/1ps

module i2c_restart_gen (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire i2c_timing_pkg::i2c_timing_t timing,
    input  wire                              scl_int,
    input  wire                              restart_en,
    output i2c_cond_pkg::line_drive_t        restart_line,
    output logic                             restart_done
);

    i2c_cond_pkg::restart_state_t state, nx_state;
    logic low_load, setup_load, hold_load;
    logic low_complete, setup_complete, hold_complete;

    i2c_period_counter i_scl_low_cnt (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (low_load),
        .en       (state == i2c_cond_pkg::RESTART_SCL_LOW),
        .period   (timing.scl_low),
        .complete (low_complete)
    );

    // setup time only runs while the sensed clock is high, so stretching extends it
    i2c_period_counter i_setup_cnt (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (setup_load),
        .en       ((state == i2c_cond_pkg::RESTART_SETUP) && scl_int),
        .period   (timing.setup),
        .complete (setup_complete)
    );

    i2c_period_counter i_hold_cnt (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (hold_load),
        .en       (state == i2c_cond_pkg::RESTART_HOLD),
        .period   (timing.hold),
        .complete (hold_complete)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= i2c_cond_pkg::RESTART_IDLE;
        end else begin
            state <= nx_state;
        end
    end

    always_comb begin
        nx_state = state;
        if (!restart_en) begin
            nx_state = i2c_cond_pkg::RESTART_IDLE;
        end else begin
            case (state)
                i2c_cond_pkg::RESTART_IDLE: nx_state = i2c_cond_pkg::RESTART_SCL_LOW;
                i2c_cond_pkg::RESTART_SCL_LOW: begin
                    if (low_complete && !low_load) begin
                        nx_state = i2c_cond_pkg::RESTART_SETUP;
                    end
                end
                i2c_cond_pkg::RESTART_SETUP: begin
                    if (setup_complete && !setup_load) begin
                        nx_state = i2c_cond_pkg::RESTART_HOLD;
                    end
                end
                i2c_cond_pkg::RESTART_HOLD: begin
                    if ((hold_complete && !hold_load) || !scl_int) begin
                        nx_state = i2c_cond_pkg::RESTART_DONE;
                    end
                end
                i2c_cond_pkg::RESTART_DONE: nx_state = i2c_cond_pkg::RESTART_DONE;
                default: nx_state = i2c_cond_pkg::RESTART_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            low_load     <= 1'b0;
            setup_load   <= 1'b0;
            hold_load    <= 1'b0;
            restart_line <= i2c_cond_pkg::RELEASED;
            restart_done <= 1'b0;
        end else begin
            low_load     <= (nx_state == i2c_cond_pkg::RESTART_SCL_LOW) &&
                            (state != i2c_cond_pkg::RESTART_SCL_LOW);
            setup_load   <= (nx_state == i2c_cond_pkg::RESTART_SETUP) &&
                            (state != i2c_cond_pkg::RESTART_SETUP);
            hold_load    <= (nx_state == i2c_cond_pkg::RESTART_HOLD) &&
                            (state != i2c_cond_pkg::RESTART_HOLD);
            restart_done <= (nx_state == i2c_cond_pkg::RESTART_DONE);
            case (nx_state)
                i2c_cond_pkg::RESTART_SCL_LOW: restart_line <= '{scl: 1'b0, sda: 1'b1};
                i2c_cond_pkg::RESTART_HOLD,
                i2c_cond_pkg::RESTART_DONE:    restart_line <= '{scl: 1'b1, sda: 1'b0};
                default:                       restart_line <= i2c_cond_pkg::RELEASED;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/i2c_start_gen.sv
// START condition FSM driving SDA low and timing the hold phase
`default_nettype none
`timescale 1ns/1ps

module i2c_start_gen (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire i2c_timing_pkg::i2c_timing_t timing,
    input  wire                              scl_int,
    input  wire                              start_en,
    output logic                             start_sda,
    output logic                             start_done
);

    i2c_cond_pkg::start_state_t state, nx_state;
    logic hold_load;
    logic hold_complete;

    i2c_period_counter i_hold_cnt (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (hold_load),
        .en       (state == i2c_cond_pkg::START_HOLD),
        .period   (timing.hold),
        .complete (hold_complete)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= i2c_cond_pkg::START_IDLE;
        end else begin
            state <= nx_state;
        end
    end

    // complete is stale during the load cycle, so it only counts once load has dropped
    always_comb begin
        nx_state = state;
        if (!start_en) begin
            nx_state = i2c_cond_pkg::START_IDLE;
        end else begin
            case (state)
                i2c_cond_pkg::START_IDLE: nx_state = i2c_cond_pkg::START_HOLD;
                i2c_cond_pkg::START_HOLD: begin
                    if ((hold_complete && !hold_load) || !scl_int) begin
                        nx_state = i2c_cond_pkg::START_DONE;
                    end
                end
                i2c_cond_pkg::START_DONE: nx_state = i2c_cond_pkg::START_DONE;
                default: nx_state = i2c_cond_pkg::START_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_load  <= 1'b0;
            start_sda  <= 1'b1;
            start_done <= 1'b0;
        end else begin
            hold_load  <= (nx_state == i2c_cond_pkg::START_HOLD) &&
                          (state != i2c_cond_pkg::START_HOLD);
            start_sda  <= (nx_state == i2c_cond_pkg::START_IDLE);
            start_done <= (nx_state == i2c_cond_pkg::START_DONE);
        end
    end

endmodule

`default_nettype wire

//--- design/i2c_period_counter.sv
// loadable down-counter with a sticky complete flag for one timed bus phase
`default_nettype none
`timescale 1ns/1ps

module i2c_period_counter (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    load,
    input  wire                    en,
    input  wire i2c_timing_pkg::count_t period,
    output logic                   complete
);

    i2c_timing_pkg::count_t cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt      <= '0;
            complete <= 1'b0;
        end else if (load) begin
            // a zero period still takes one counting cycle
            cnt      <= (period == '0) ? i2c_timing_pkg::count_t'(1) : period;
            complete <= 1'b0;
        end else if (en && !complete) begin
            if (cnt <= i2c_timing_pkg::count_t'(1)) begin
                cnt      <= '0;
                complete <= 1'b1;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/i2c_cond_pkg.sv
// line drive struct, released constant and state types of the START, restart and STOP generators
`default_nettype none

package i2c_cond_pkg;

    // a 1 releases the line (pulled high) and a 0 drives it low
    typedef struct packed {
        logic scl;
        logic sda;
    } line_drive_t;

    localparam line_drive_t RELEASED = '{scl: 1'b1, sda: 1'b1};

    typedef enum logic [1:0] {
        START_IDLE,
        START_HOLD,
        START_DONE
    } start_state_t;

    typedef enum logic [2:0] {
        RESTART_IDLE,
        RESTART_SCL_LOW,
        RESTART_SETUP,
        RESTART_HOLD,
        RESTART_DONE
    } restart_state_t;

    typedef enum logic [1:0] {
        STOP_IDLE,
        STOP_SCL_LOW,
        STOP_SETUP,
        STOP_DONE
    } stop_state_t;

endpackage

`default_nettype wire

//--- design/i2c_timing_pkg.sv
// period count width, count type and timing configuration struct for the I2C condition generators
`default_nettype none

package i2c_timing_pkg;

    localparam int CNT_W = 16;

    // one bus phase length in clock cycles
    typedef logic [CNT_W-1:0] count_t;

    // periods of the three timed phases, a value of 0 behaves as 1
    typedef struct packed {
        count_t scl_low;
        count_t setup;
        count_t hold;
    } i2c_timing_t;

endpackage

`default_nettype wire
